// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - design/mem_stage_pkg.sv
      - design/credit_fifo.sv
      - design/data_access_unit.sv
      - design/mem_stage_top.sv
  - target: simulation
    files:
      - testbench/mem_stage_checker.sv
      - testbench/tb_mem_stage.sv

// File: compile.f
design/mem_stage_pkg.sv
design/credit_fifo.sv
design/data_access_unit.sv
design/mem_stage_top.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

// File: design/credit_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module credit_fifo #(
    parameter type         payload_t    = logic,
    parameter int unsigned DEPTH        = 4,
    parameter int unsigned SEND_CREDITS = 0
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     push_valid,
    input  payload_t push_data,
    output logic     credit_return,
    output logic     pop_valid,
    output payload_t pop_data,
    input  logic     pop_take,
    input  logic     pop_credit
);

    localparam int AW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW  = $clog2(DEPTH + 1);
    localparam int SCW = (SEND_CREDITS > 0) ? $clog2(SEND_CREDITS + 1) : 1;

    payload_t         mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic [SCW-1:0]   send_cnt;
    logic             not_empty;
    logic             has_credit;
    logic             want_pop;
    logic             pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign pop       = not_empty && want_pop;
    assign pop_valid = not_empty && has_credit;
    assign pop_data  = mem[rd_ptr];

    generate
        if (SEND_CREDITS > 0) begin : g_send
            // Self-timed pop, paced by credits from the receiver
            always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                    send_cnt <= SCW'(SEND_CREDITS);
                end else begin
                    send_cnt <= send_cnt - SCW'(pop) + SCW'(pop_credit);
                end
            end
            assign has_credit = (send_cnt != '0);
            assign want_pop   = has_credit;
        end else begin : g_take
            // Receiver pops by request
            assign send_cnt   = '0;
            assign has_credit = 1'b1;
            assign want_pop   = pop_take;
        end
    endgenerate

    // Storage
    always_ff @(posedge CLK) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count         <= count + CW'(push_valid) - CW'(pop);
            // One credit back to the sender per freed slot
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

// File: design/data_access_unit.sv
`timescale 1ns/100ps
`default_nettype none

module data_access_unit (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     op_valid,
    input  mem_stage_pkg::mem_op_t   op,
    output logic                     take,
    output logic                     res_valid,
    output mem_stage_pkg::wb_result_t res,
    input  logic                     res_credit
);

    import mem_stage_pkg::*;

    localparam int CCW = $clog2(OUT_DEPTH + 1);

    logic [CCW-1:0]     credits;
    logic [1:0]         offset;
    logic [DMEM_AW-1:0] idx;
    logic               is_load;
    logic               is_store;
    logic [3:0]         lanes;
    logic               misaligned;
    word_t              store_data;
    word_t              dmem [DMEM_WORDS];

    // Result stage registers
    word_t              rdata_q;
    mem_kind_t          kind_q;
    reg_idx_t           rd_q;
    logic [1:0]         offset_q;
    logic               mis_q;
    word_t              addr_q;
    word_t              imm_q;
    logic [7:0]         byte_sel;
    logic [15:0]        half_sel;

    // Take the head only with room downstream
    assign take   = op_valid && (credits != '0);
    assign offset = op.addr[1:0];
    assign idx    = op.addr[DMEM_AW+1:2];

    // Lane decode and alignment check
    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        lanes      = 4'b0000;
        misaligned = 1'b0;
        store_data = '0;
        case (op.kind)
            LB, LBU, SB: begin
                lanes      = 4'b0001 << offset;
                store_data = {4{op.rs2_data[7:0]}};
            end
            LH, LHU, SH: begin
                lanes      = offset[1] ? 4'b1100 : 4'b0011;
                misaligned = offset[0];
                store_data = {2{op.rs2_data[15:0]}};
            end
            LW, SW: begin
                lanes      = 4'b1111;
                misaligned = (offset != 2'b00);
                store_data = op.rs2_data;
            end
            default: begin
            end
        endcase
        is_load  = op.kind inside {LB, LH, LW, LBU, LHU};
        is_store = op.kind inside {SB, SH, SW};
    end

    // Data RAM, single access per cycle
    always_ff @(posedge CLK) begin
        if (take && is_store && !misaligned) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes[i]) begin
                    dmem[idx][8*i +: 8] <= store_data[8*i +: 8];
                end
            end
        end
        if (take && is_load && !misaligned) begin
            rdata_q <= dmem[idx];
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            kind_q   <= op.kind;
            rd_q     <= op.rd;
            offset_q <= offset;
            mis_q    <= misaligned;
            addr_q   <= op.addr;
            imm_q    <= op.imm_u;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            credits   <= CCW'(OUT_DEPTH);
            res_valid <= 1'b0;
        end else begin
            credits   <= credits - CCW'(take) + CCW'(res_credit);
            res_valid <= take;
        end
    end

    // Lane pick for loads
    assign byte_sel = rdata_q[{offset_q, 3'b000} +: 8];
    assign half_sel = rdata_q[{offset_q[1], 4'b0000} +: 16];

    // Writeback select
    always_comb begin
        res.rd        = rd_q;
        res.reg_write = 1'b0;
        res.wdata     = '0;
        res.exc       = EXC_NONE;
        res.badaddr   = '0;
        if (mis_q) begin
            res.exc     = (kind_q inside {SB, SH, SW}) ? EXC_MAL_STORE : EXC_MAL_LOAD;
            res.badaddr = addr_q;
        end else begin
            case (kind_q)
                LB:  res.wdata = {{24{byte_sel[7]}}, byte_sel};
                LBU: res.wdata = {24'h0, byte_sel};
                LH:  res.wdata = {{16{half_sel[15]}}, half_sel};
                LHU: res.wdata = {16'h0, half_sel};
                LW:  res.wdata = rdata_q;
                ALU: res.wdata = addr_q;
                LUI: res.wdata = imm_q;
                default: res.wdata = '0;
            endcase
            // Stores write no register
            res.reg_write = !(kind_q inside {SB, SH, SW});
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // Data RAM geometry, indexed by addr[7:2]
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Queue depths, which double as initial credits
    localparam int IN_DEPTH   = 4;
    localparam int OUT_DEPTH  = 4;

    // Credits granted by the writeback stage
    localparam int WB_CREDITS = 2;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Operation kinds handled by the memory stage
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7,
        ALU = 4'd8,
        LUI = 4'd9
    } mem_kind_t;

    // Operation from the execute stage
    typedef struct packed {
        mem_kind_t kind;
        reg_idx_t  rd;
        // ALU result, used as the effective address
        word_t     addr;
        word_t     rs2_data;
        word_t     imm_u;
    } mem_op_t;

    // Only misalignment is reported
    typedef enum logic [1:0] {
        EXC_NONE      = 2'd0,
        EXC_MAL_LOAD  = 2'd1,
        EXC_MAL_STORE = 2'd2
    } exc_t;

    // Result toward the writeback stage
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        word_t    wdata;
        exc_t     exc;
        word_t    badaddr;
    } wb_result_t;

endpackage

`default_nettype wire

// File: design/mem_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      in_valid,
    input  mem_stage_pkg::mem_op_t    in_op,
    output logic                      in_credit,
    output logic                      out_valid,
    output mem_stage_pkg::wb_result_t out_result,
    input  logic                      out_credit
);

    import mem_stage_pkg::*;

    // Input FIFO to access unit
    logic       head_valid;
    mem_op_t    head_op;
    logic       take;

    // Access unit to output FIFO
    logic       dau_valid;
    wb_result_t dau_res;
    logic       dau_credit;

    // Operation queue, popped on request
    credit_fifo #(
        .payload_t    (mem_op_t),
        .DEPTH        (IN_DEPTH),
        .SEND_CREDITS (0)
    ) i_in_fifo (
        .CLK           (CLK),
        .nRST          (nRST),
        .push_valid    (in_valid),
        .push_data     (in_op),
        .credit_return (in_credit),
        .pop_valid     (head_valid),
        .pop_data      (head_op),
        .pop_take      (take),
        .pop_credit    (1'b0)
    );

    data_access_unit i_dau (
        .CLK        (CLK),
        .nRST       (nRST),
        .op_valid   (head_valid),
        .op         (head_op),
        .take       (take),
        .res_valid  (dau_valid),
        .res        (dau_res),
        .res_credit (dau_credit)
    );

    // Result queue, sends on writeback credits
    credit_fifo #(
        .payload_t    (wb_result_t),
        .DEPTH        (OUT_DEPTH),
        .SEND_CREDITS (WB_CREDITS)
    ) i_out_fifo (
        .CLK           (CLK),
        .nRST          (nRST),
        .push_valid    (dau_valid),
        .push_data     (dau_res),
        .credit_return (dau_credit),
        .pop_valid     (out_valid),
        .pop_data      (out_result),
        .pop_take      (1'b0),
        .pop_credit    (out_credit)
    );

endmodule

`default_nettype wire

// File: testbench/mem_stage_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_checker #(
    parameter int unsigned DEPTH        = 4,
    parameter int unsigned SEND_CREDITS = 0
) (
    input logic                                 CLK,
    input logic                                 nRST,
    input logic [$clog2(DEPTH + 1)-1:0]         count,
    input logic                                 pop_take,
    input logic                                 pop_valid,
    input logic                                 pop_credit,
    input logic [((SEND_CREDITS > 0) ? $clog2(SEND_CREDITS + 1) : 1)-1:0] send_cnt
);

    // Read back by the testbench at the end of the run
    int fail_count = 0;

    // Sent items the receiver has not credited yet
    int in_flight;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            in_flight <= 0;
        end else if (SEND_CREDITS > 0) begin
            in_flight <= in_flight + int'(pop_valid) - int'(pop_credit);
        end
    end

    a_occupancy: assert property (@(posedge CLK) disable iff (!nRST) count <= DEPTH)
        else begin
            fail_count++;
            $error("FIFO occupancy %0d above depth %0d", count, DEPTH);
        end

    a_pop_empty: assert property (@(posedge CLK) disable iff (!nRST) pop_take |-> count != '0)
        else begin
            fail_count++;
            $error("Pop requested while FIFO empty");
        end

    a_send_max: assert property (@(posedge CLK) disable iff (!nRST) send_cnt <= SEND_CREDITS)
        else begin
            fail_count++;
            $error("Send counter %0d above %0d", send_cnt, SEND_CREDITS);
        end

    // Outgoing valid needs a credit in hand
    a_valid_credit: assert property (@(posedge CLK) disable iff (!nRST)
        pop_valid |-> (SEND_CREDITS == 0) || (in_flight < int'(SEND_CREDITS)))
        else begin
            fail_count++;
            $error("Outgoing valid with no send credit");
        end

endmodule

bind credit_fifo mem_stage_checker #(
    .DEPTH        (DEPTH),
    .SEND_CREDITS (SEND_CREDITS)
) i_checker (
    .CLK        (CLK),
    .nRST       (nRST),
    .count      (count),
    .pop_take   (pop_take),
    .pop_valid  (pop_valid),
    .pop_credit (pop_credit),
    .send_cnt   (send_cnt)
);

`default_nettype wire

// File: testbench/tb_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_stage;

    import mem_stage_pkg::*;

    logic       CLK;
    logic       nRST;
    logic       in_valid;
    mem_op_t    in_op;
    logic       in_credit;
    logic       out_valid;
    wb_result_t out_result;
    logic       out_credit;

    // Reference model state
    word_t      model_mem [DMEM_WORDS];
    wb_result_t exp_q [$];
    int         due_q [$];
    int         up_credits;
    int         credit_pulses;
    int         sent;
    int         received;
    int         cycle;

    mem_stage_top i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("TEST FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Expected result from the access rules; updates the model RAM for stores
    function automatic wb_result_t model_step(input mem_op_t op);
        wb_result_t  r;
        int          off;
        int          idx;
        logic        mis;
        logic        store;
        logic [7:0]  b;
        logic [15:0] h;
        r     = '0;
        r.rd  = op.rd;
        off   = op.addr[1:0];
        idx   = op.addr[7:2];
        store = op.kind inside {SB, SH, SW};
        mis   = ((op.kind inside {LH, LHU, SH}) && (off % 2 == 1))
              || ((op.kind inside {LW, SW}) && (off != 0));
        if (mis) begin
            r.exc     = store ? EXC_MAL_STORE : EXC_MAL_LOAD;
            r.badaddr = op.addr;
            return r;
        end
        b           = model_mem[idx][8*off +: 8];
        h           = model_mem[idx][16*(off/2) +: 16];
        r.reg_write = !store;
        case (op.kind)
            LB:  r.wdata = {{24{b[7]}}, b};
            LBU: r.wdata = {24'h0, b};
            LH:  r.wdata = {{16{h[15]}}, h};
            LHU: r.wdata = {16'h0, h};
            LW:  r.wdata = model_mem[idx];
            ALU: r.wdata = op.addr;
            LUI: r.wdata = op.imm_u;
            SB:  model_mem[idx][8*off +: 8] = op.rs2_data[7:0];
            SH:  model_mem[idx][16*(off/2) +: 16] = op.rs2_data[15:0];
            SW:  model_mem[idx] = op.rs2_data;
            default: begin
            end
        endcase
        return r;
    endfunction

    function automatic mem_op_t random_op();
        mem_op_t op;
        word_t   r;
        op.kind     = mem_kind_t'($urandom_range(9, 0));
        op.rd       = 5'($urandom);
        op.rs2_data = $urandom;
        op.imm_u    = $urandom & 32'hFFFF_F000;
        r           = $urandom;
        op.addr     = {24'h0, r[7:2], 2'b00};
        // About one in four halfword or word accesses misaligned
        case (op.kind)
            LB, LBU, SB: op.addr[1:0] = r[9:8];
            LH, LHU, SH: op.addr[1:0] = {r[12], r[11:10] == 2'b00};
            LW, SW: begin
                if (r[11:10] == 2'b00) begin
                    op.addr[1:0] = (r[13:12] == 2'b00) ? 2'b10 : r[13:12];
                end
            end
            ALU: op.addr = r;
            default: begin
            end
        endcase
        return op;
    endfunction

    // One cycle on the upstream side
    task automatic tick();
        @(negedge CLK);
        in_valid = 1'b0;
        if (in_credit) begin
            up_credits++;
            credit_pulses++;
        end
    endtask

    task automatic send_op(input mem_op_t op);
        int waited;
        waited = 0;
        tick();
        while (up_credits == 0) begin
            if (waited == 200) begin
                abort_run("No input credit came back");
            end
            waited++;
            tick();
        end
        in_valid = 1'b1;
        in_op    = op;
        up_credits--;
        exp_q.push_back(model_step(op));
        sent++;
    endtask

    task automatic compare_result(input wb_result_t want);
        check_equal("rd", out_result.rd, want.rd);
        check_equal("reg_write", out_result.reg_write, want.reg_write);
        check_equal("exc", out_result.exc, want.exc);
        if (want.exc != EXC_NONE) begin
            check_equal("badaddr", out_result.badaddr, want.badaddr);
        end
        if (want.reg_write) begin
            check_equal("wdata", out_result.wdata, want.wdata);
        end
    endtask

    // Writeback side with random credit delay
    always @(negedge CLK) begin
        wb_result_t want;
        int         slot;
        if (nRST) begin
            cycle++;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("Result arrived with no operation outstanding");
                end
                want = exp_q.pop_front();
                compare_result(want);
                received++;
                due_q.push_back(cycle + $urandom_range(6, 0));
            end
            out_credit = 1'b0;
            slot       = -1;
            foreach (due_q[i]) begin
                if (slot < 0 && due_q[i] <= cycle) begin
                    slot = i;
                end
            end
            if (slot >= 0) begin
                due_q.delete(slot);
                out_credit = 1'b1;
            end
        end
    end

    initial begin
        mem_op_t op;
        int      waited;
        int      fails;
        void'($urandom(3));
        nRST          = 1'b0;
        in_valid      = 1'b0;
        in_op         = '0;
        out_credit    = 1'b0;
        up_credits    = IN_DEPTH;
        credit_pulses = 0;
        sent          = 0;
        received      = 0;
        cycle         = 0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        // Quiet outputs before any traffic
        repeat (8) begin
            tick();
            check_equal("in_credit before traffic", in_credit, 0);
            check_equal("out_valid before traffic", out_valid, 0);
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            op          = '0;
            op.kind     = SW;
            op.addr     = i * 4;
            op.rs2_data = $urandom;
            send_op(op);
        end
        for (int n = 0; n < 400; n++) begin
            if ($urandom_range(3, 0) == 0) begin
                tick();
            end
            send_op(random_op());
        end
        waited = 0;
        while (received != sent) begin
            if (waited == 3000) begin
                abort_run("Pipeline did not drain");
            end
            waited++;
            tick();
        end
        // Stray results would show up here
        repeat (10) tick();
        check_equal("in_credit pulses", credit_pulses, sent);
        fails = i_dut.i_in_fifo.i_checker.fail_count + i_dut.i_out_fifo.i_checker.fail_count;
        if (fails != 0) begin
            $display("Credit FIFO assertions failed %0d times", fails);
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
